// ==== pinmux_pkg.sv ====
// Register map and widths for the 8-pad mux; byte-addressed 8-bit offsets and at most 8 pads
package pinmux_pkg;

  //--------------------------------------------------------------------------
  // Pad and register bus widths
  //--------------------------------------------------------------------------
  localparam int unsigned PAD_W       = 8;
  localparam int unsigned REG_AW      = 8;
  localparam int unsigned REG_DW      = 32;
  localparam int unsigned REG_BEW     = REG_DW / 8;

  // PWM channel count and phase count width
  localparam int unsigned PWM_N       = 2;
  localparam int unsigned PWM_CNT_W   = 16;

  // Tick divider widths
  localparam int unsigned PULSE_CFG_W   = 10;
  localparam int unsigned MS_PER_US_CNT = 1000;
  localparam int unsigned MS_CNT_W      = 10;

  //--------------------------------------------------------------------------
  // Register offsets
  //--------------------------------------------------------------------------
  localparam logic [REG_AW-1:0] REG_GPIO_DIR   = 8'h00;
  localparam logic [REG_AW-1:0] REG_GPIO_OUT   = 8'h04;
  // Read only, synchronized pad inputs
  localparam logic [REG_AW-1:0] REG_GPIO_IN    = 8'h08;
  localparam logic [REG_AW-1:0] REG_MULTI_FUNC = 8'h0C;
  localparam logic [REG_AW-1:0] REG_PULSE_1US  = 8'h10;
  // High count in [15:0], low count in [31:16]
  localparam logic [REG_AW-1:0] REG_PWM0       = 8'h14;
  localparam logic [REG_AW-1:0] REG_PWM1       = 8'h18;

  // Multi-function register fields
  localparam int unsigned FN_PWM_LSB  = 0;
  localparam int unsigned FN_UART_BIT = 8;

  //--------------------------------------------------------------------------
  // Pad positions of the alternate functions
  //--------------------------------------------------------------------------
  localparam int unsigned PAD_UART_RXD = 0;
  localparam int unsigned PAD_UART_TXD = 1;
  localparam int unsigned PAD_PWM0     = 3;
  localparam int unsigned PAD_PWM1     = 5;

endpackage

// ==== pinmux_regs.sv ====
// Every access acks one cycle after reg_cs_i and the master must hold its request until then
`timescale 1ns/100ps

module pinmux_regs (
  input  logic                                 mclk,
  input  logic                                 rst_n_i,
  // Register bus
  input  logic                                 reg_cs_i,
  input  logic                                 reg_wr_i,
  input  logic [pinmux_pkg::REG_AW-1:0]        reg_addr_i,
  input  logic [pinmux_pkg::REG_DW-1:0]        reg_wdata_i,
  input  logic [pinmux_pkg::REG_BEW-1:0]       reg_be_i,
  output logic [pinmux_pkg::REG_DW-1:0]        reg_rdata_o,
  output logic                                 reg_ack_o,
  // Raw pad inputs
  input  logic [pinmux_pkg::PAD_W-1:0]         pad_in_i,
  // Configuration outputs
  output logic [pinmux_pkg::PAD_W-1:0]         cfg_gpio_dir_o,
  output logic [pinmux_pkg::PAD_W-1:0]         cfg_gpio_out_o,
  output logic                                 cfg_uart_enb_o,
  output logic [pinmux_pkg::PWM_N-1:0]         cfg_pwm_enb_o,
  output logic [pinmux_pkg::PULSE_CFG_W-1:0]   cfg_pulse_1us_o,
  output logic [pinmux_pkg::PWM_CNT_W-1:0]     cfg_pwm0_high_o,
  output logic [pinmux_pkg::PWM_CNT_W-1:0]     cfg_pwm0_low_o,
  output logic [pinmux_pkg::PWM_CNT_W-1:0]     cfg_pwm1_high_o,
  output logic [pinmux_pkg::PWM_CNT_W-1:0]     cfg_pwm1_low_o
);

  import pinmux_pkg::*;

  logic              wr_stb;
  logic              rd_stb;
  logic [REG_DW-1:0] be_mask;
  logic [REG_DW-1:0] wdat;
  logic [REG_DW-1:0] rd_mux;
  logic [REG_DW-1:0] pwm0_reg;
  logic [REG_DW-1:0] pwm1_reg;
  logic [PAD_W-1:0]  pad_sync1;
  logic [PAD_W-1:0]  pad_sync2;

  // Access is taken on the edge that raises the ack
  assign wr_stb = reg_cs_i & reg_wr_i & ~reg_ack_o;
  assign rd_stb = reg_cs_i & ~reg_wr_i & ~reg_ack_o;

  // Byte enables widened to a bit mask
  always_comb begin
    for (int b = 0; b < REG_BEW; b++) begin
      be_mask[8*b +: 8] = {8{reg_be_i[b]}};
    end
  end

  assign wdat = reg_wdata_i & be_mask;

  //--------------------------------------------------------------------------
  // Ack and read data
  //--------------------------------------------------------------------------
  // Single-cycle ack, one edge after cs is seen
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      reg_ack_o <= 1'b0;
    end else begin
      reg_ack_o <= reg_cs_i & ~reg_ack_o;
    end
  end

  // Only implemented fields read back, rest is zero
  always_comb begin
    rd_mux = '0;
    case (reg_addr_i)
      REG_GPIO_DIR:   rd_mux[PAD_W-1:0] = cfg_gpio_dir_o;
      REG_GPIO_OUT:   rd_mux[PAD_W-1:0] = cfg_gpio_out_o;
      REG_GPIO_IN:    rd_mux[PAD_W-1:0] = pad_sync2;
      REG_MULTI_FUNC: begin
        rd_mux[FN_PWM_LSB +: PWM_N] = cfg_pwm_enb_o;
        rd_mux[FN_UART_BIT]         = cfg_uart_enb_o;
      end
      REG_PULSE_1US:  rd_mux[PULSE_CFG_W-1:0] = cfg_pulse_1us_o;
      REG_PWM0:       rd_mux = pwm0_reg;
      REG_PWM1:       rd_mux = pwm1_reg;
      default:        rd_mux = '0;
    endcase
  end

  always_ff @(posedge mclk) begin
    if (rd_stb) begin
      reg_rdata_o <= rd_mux;
    end
  end

  //--------------------------------------------------------------------------
  // Configuration registers, byte-enabled writes
  //--------------------------------------------------------------------------
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_gpio_dir_o  <= '0;
      cfg_gpio_out_o  <= '0;
      cfg_pwm_enb_o   <= '0;
      cfg_uart_enb_o  <= 1'b0;
      cfg_pulse_1us_o <= '0;
      pwm0_reg        <= '0;
      pwm1_reg        <= '0;
    end else if (wr_stb) begin
      case (reg_addr_i)
        REG_GPIO_DIR: begin
          cfg_gpio_dir_o <= (cfg_gpio_dir_o & ~be_mask[PAD_W-1:0]) | wdat[PAD_W-1:0];
        end
        REG_GPIO_OUT: begin
          cfg_gpio_out_o <= (cfg_gpio_out_o & ~be_mask[PAD_W-1:0]) | wdat[PAD_W-1:0];
        end
        REG_MULTI_FUNC: begin
          cfg_pwm_enb_o  <= (cfg_pwm_enb_o & ~be_mask[FN_PWM_LSB +: PWM_N])
                            | wdat[FN_PWM_LSB +: PWM_N];
          cfg_uart_enb_o <= (cfg_uart_enb_o & ~be_mask[FN_UART_BIT]) | wdat[FN_UART_BIT];
        end
        REG_PULSE_1US: begin
          cfg_pulse_1us_o <= (cfg_pulse_1us_o & ~be_mask[PULSE_CFG_W-1:0])
                             | wdat[PULSE_CFG_W-1:0];
        end
        REG_PWM0: pwm0_reg <= (pwm0_reg & ~be_mask) | wdat;
        REG_PWM1: pwm1_reg <= (pwm1_reg & ~be_mask) | wdat;
        // Unmapped, write dropped
        default: ;
      endcase
    end
  end

  assign cfg_pwm0_high_o = pwm0_reg[PWM_CNT_W-1:0];
  assign cfg_pwm0_low_o  = pwm0_reg[REG_DW-1:PWM_CNT_W];
  assign cfg_pwm1_high_o = pwm1_reg[PWM_CNT_W-1:0];
  assign cfg_pwm1_low_o  = pwm1_reg[REG_DW-1:PWM_CNT_W];

  // Pad input synchronizer, 2 stages
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pad_sync1 <= '0;
      pad_sync2 <= '0;
    end else begin
      pad_sync1 <= pad_in_i;
      pad_sync2 <= pad_sync1;
    end
  end

  // Master holds cs through the ack cycle, so a second ack would be a new access
  a_ack_one_cycle: assert property (@(posedge mclk) disable iff (!rst_n_i)
    reg_ack_o |=> !reg_ack_o)
    else $error("[FAIL] %0t reg_ack_o high in two consecutive cycles", $time);

endmodule

// ==== pinmux_tick_gen.sv ====
// A divider setting of N gives a 1 us tick every N+1 clocks and any change restarts both ticks
`timescale 1ns/100ps

module pinmux_tick_gen (
  input  logic                                mclk,
  input  logic                                rst_n_i,
  input  logic [pinmux_pkg::PULSE_CFG_W-1:0]  cfg_pulse_1us_i,
  output logic                                pulse_1us_o,
  output logic                                pulse_1ms_o
);

  import pinmux_pkg::*;

  logic [PULSE_CFG_W-1:0] us_cnt;
  logic [PULSE_CFG_W-1:0] cfg_q;
  logic [MS_CNT_W-1:0]    ms_cnt;
  logic                   cfg_chg;
  logic                   ms_wrap;

  // Divider setting rewritten since last cycle
  assign cfg_chg = (cfg_pulse_1us_i != cfg_q);
  assign ms_wrap = (ms_cnt == MS_CNT_W'(MS_PER_US_CNT - 1));

  //--------------------------------------------------------------------------
  // us divider feeding the ms divider
  //--------------------------------------------------------------------------
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q       <= '0;
      us_cnt      <= '0;
      ms_cnt      <= '0;
      pulse_1us_o <= 1'b0;
      pulse_1ms_o <= 1'b0;
    end else begin
      cfg_q <= cfg_pulse_1us_i;
      if (cfg_chg) begin
        // Restart both dividers
        us_cnt      <= '0;
        ms_cnt      <= '0;
        pulse_1us_o <= 1'b0;
        pulse_1ms_o <= 1'b0;
      end else if (us_cnt == cfg_pulse_1us_i) begin
        us_cnt      <= '0;
        pulse_1us_o <= 1'b1;
        // ms tick rides on every 1000th us tick
        if (ms_wrap) begin
          ms_cnt      <= '0;
          pulse_1ms_o <= 1'b1;
        end else begin
          ms_cnt      <= ms_cnt + 1'b1;
          pulse_1ms_o <= 1'b0;
        end
      end else begin
        us_cnt      <= us_cnt + 1'b1;
        pulse_1us_o <= 1'b0;
        pulse_1ms_o <= 1'b0;
      end
    end
  end

  a_ms_on_us: assert property (@(posedge mclk) disable iff (!rst_n_i)
    pulse_1ms_o |-> pulse_1us_o)
    else $error("[FAIL] %0t pulse_1ms_o without pulse_1us_o", $time);

endmodule

// ==== pinmux_pwm.sv ====
// Phase lengths count ms ticks and a count of zero acts as one
`timescale 1ns/100ps

module pinmux_pwm (
  input  logic                              mclk,
  input  logic                              rst_n_i,
  input  logic                              pulse_1ms_i,
  input  logic                              cfg_enb_i,
  input  logic [pinmux_pkg::PWM_CNT_W-1:0]  cfg_high_i,
  input  logic [pinmux_pkg::PWM_CNT_W-1:0]  cfg_low_i,
  output logic                              waveform_o
);

  import pinmux_pkg::*;

  logic                 active;
  logic [PWM_CNT_W-1:0] ms_cnt;
  logic [PWM_CNT_W-1:0] phase_len;
  logic [PWM_CNT_W-1:0] phase_last;

  // Length of the phase in progress
  assign phase_len  = waveform_o ? cfg_high_i : cfg_low_i;
  assign phase_last = (phase_len == '0) ? '0 : phase_len - 1'b1;

  //--------------------------------------------------------------------------
  // Phase flag and ms counter
  //--------------------------------------------------------------------------
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active     <= 1'b0;
      waveform_o <= 1'b0;
      ms_cnt     <= '0;
    end else if (!cfg_enb_i) begin
      // Idle low, counter parked
      active     <= 1'b0;
      waveform_o <= 1'b0;
      ms_cnt     <= '0;
    end else if (!active) begin
      // First enabled cycle starts the high phase
      active     <= 1'b1;
      waveform_o <= 1'b1;
      ms_cnt     <= '0;
    end else if (pulse_1ms_i) begin
      if (ms_cnt >= phase_last) begin
        ms_cnt     <= '0;
        waveform_o <= ~waveform_o;
      end else begin
        ms_cnt <= ms_cnt + 1'b1;
      end
    end
  end

  a_off_when_disabled: assert property (@(posedge mclk) disable iff (!rst_n_i)
    !cfg_enb_i |=> !waveform_o)
    else $error("[FAIL] %0t PWM waveform high after disable", $time);

endmodule

// ==== pinmux_pad_mux.sv ====
// Purely combinational so pads change in the same cycle as the register write ack
`timescale 1ns/100ps

module pinmux_pad_mux (
  input  logic [pinmux_pkg::PAD_W-1:0]  cfg_gpio_dir_i,
  input  logic [pinmux_pkg::PAD_W-1:0]  cfg_gpio_out_i,
  input  logic                          cfg_uart_enb_i,
  input  logic [pinmux_pkg::PWM_N-1:0]  cfg_pwm_enb_i,
  input  logic [pinmux_pkg::PWM_N-1:0]  pwm_wfm_i,
  input  logic                          uart_txd_i,
  input  logic [pinmux_pkg::PAD_W-1:0]  pad_in_i,
  output logic [pinmux_pkg::PAD_W-1:0]  pad_out_o,
  output logic [pinmux_pkg::PAD_W-1:0]  pad_oen_o,
  output logic                          uart_rxd_o,
  output logic [pinmux_pkg::PAD_W-1:0]  pad_in_o
);

  import pinmux_pkg::*;

  //--------------------------------------------------------------------------
  // Pad map
  //   pad 0  GPIO / UART RXD
  //   pad 1  GPIO / UART TXD
  //   pad 3  GPIO / PWM0
  //   pad 5  GPIO / PWM1
  //   others GPIO only
  //--------------------------------------------------------------------------

  // Output and output-enable, later statements win
  always_comb begin
    pad_out_o = '0;
    pad_oen_o = '1;

    // GPIO rule, lowest priority
    for (int i = 0; i < PAD_W; i++) begin
      if (cfg_gpio_dir_i[i]) begin
        pad_out_o[i] = cfg_gpio_out_i[i];
        pad_oen_o[i] = 1'b0;
      end
    end

    // PWM channels
    if (cfg_pwm_enb_i[0]) begin
      pad_out_o[PAD_PWM0] = pwm_wfm_i[0];
      pad_oen_o[PAD_PWM0] = 1'b0;
    end
    if (cfg_pwm_enb_i[1]) begin
      pad_out_o[PAD_PWM1] = pwm_wfm_i[1];
      pad_oen_o[PAD_PWM1] = 1'b0;
    end

    // UART takes pads 0 and 1
    if (cfg_uart_enb_i) begin
      pad_out_o[PAD_UART_RXD] = 1'b0;
      pad_oen_o[PAD_UART_RXD] = 1'b1;
      pad_out_o[PAD_UART_TXD] = uart_txd_i;
      pad_oen_o[PAD_UART_TXD] = 1'b0;
    end
  end

  // RXD held low while UART is off
  assign uart_rxd_o = cfg_uart_enb_i & pad_in_i[PAD_UART_RXD];

  // Raw inputs go back to the register bank synchronizer
  assign pad_in_o = pad_in_i;

  // RXD pad must never be driven by the mux when UART owns it
  always_comb begin
    if (cfg_uart_enb_i) begin
      a_rxd_input: assert final (pad_oen_o[PAD_UART_RXD])
        else $error("[FAIL] %0t RXD pad driven while UART enabled", $time);
    end
  end

endmodule

// ==== pinmux_top.sv ====
// Submodules leave reset two mclk edges after arst_n_i rises and the pad input is not debounced
`timescale 1ns/100ps

module pinmux_top (
  input  logic                           mclk,
  input  logic                           arst_n_i,
  // Register bus
  input  logic                           reg_cs_i,
  input  logic                           reg_wr_i,
  input  logic [pinmux_pkg::REG_AW-1:0]  reg_addr_i,
  input  logic [pinmux_pkg::REG_DW-1:0]  reg_wdata_i,
  input  logic [pinmux_pkg::REG_BEW-1:0] reg_be_i,
  output logic [pinmux_pkg::REG_DW-1:0]  reg_rdata_o,
  output logic                           reg_ack_o,
  // Pads
  input  logic [pinmux_pkg::PAD_W-1:0]   pad_in_i,
  output logic [pinmux_pkg::PAD_W-1:0]   pad_out_o,
  output logic [pinmux_pkg::PAD_W-1:0]   pad_oen_o,
  // UART
  input  logic                           uart_txd_i,
  output logic                           uart_rxd_o
);

  import pinmux_pkg::*;

  logic [1:0]             rst_sync;
  logic                   sreset_n;
  logic [PAD_W-1:0]       cfg_gpio_dir;
  logic [PAD_W-1:0]       cfg_gpio_out;
  logic                   cfg_uart_enb;
  logic [PWM_N-1:0]       cfg_pwm_enb;
  logic [PULSE_CFG_W-1:0] cfg_pulse_1us;
  logic [PWM_CNT_W-1:0]   cfg_pwm0_high;
  logic [PWM_CNT_W-1:0]   cfg_pwm0_low;
  logic [PWM_CNT_W-1:0]   cfg_pwm1_high;
  logic [PWM_CNT_W-1:0]   cfg_pwm1_low;
  logic [PAD_W-1:0]       pad_in_raw;
  logic [PWM_N-1:0]       pwm_wfm;
  logic                   pulse_1ms;

  //--------------------------------------------------------------------------
  // Reset synchronizer, async assert and sync release
  //--------------------------------------------------------------------------
  always_ff @(posedge mclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign sreset_n = rst_sync[1];

  pinmux_regs u_regs (
    .mclk            (mclk),
    .rst_n_i         (sreset_n),
    .reg_cs_i        (reg_cs_i),
    .reg_wr_i        (reg_wr_i),
    .reg_addr_i      (reg_addr_i),
    .reg_wdata_i     (reg_wdata_i),
    .reg_be_i        (reg_be_i),
    .reg_rdata_o     (reg_rdata_o),
    .reg_ack_o       (reg_ack_o),
    .pad_in_i        (pad_in_raw),
    .cfg_gpio_dir_o  (cfg_gpio_dir),
    .cfg_gpio_out_o  (cfg_gpio_out),
    .cfg_uart_enb_o  (cfg_uart_enb),
    .cfg_pwm_enb_o   (cfg_pwm_enb),
    .cfg_pulse_1us_o (cfg_pulse_1us),
    .cfg_pwm0_high_o (cfg_pwm0_high),
    .cfg_pwm0_low_o  (cfg_pwm0_low),
    .cfg_pwm1_high_o (cfg_pwm1_high),
    .cfg_pwm1_low_o  (cfg_pwm1_low)
  );

  // 1 ms tick feeds the PWM channels, the 1 us tick stays internal
  pinmux_tick_gen u_tick_gen (
    .mclk            (mclk),
    .rst_n_i         (sreset_n),
    .cfg_pulse_1us_i (cfg_pulse_1us),
    .pulse_1us_o     (),
    .pulse_1ms_o     (pulse_1ms)
  );

  // PWM0 on pad 3
  pinmux_pwm u_pwm_0 (
    .mclk        (mclk),
    .rst_n_i     (sreset_n),
    .pulse_1ms_i (pulse_1ms),
    .cfg_enb_i   (cfg_pwm_enb[0]),
    .cfg_high_i  (cfg_pwm0_high),
    .cfg_low_i   (cfg_pwm0_low),
    .waveform_o  (pwm_wfm[0])
  );

  // PWM1 on pad 5
  pinmux_pwm u_pwm_1 (
    .mclk        (mclk),
    .rst_n_i     (sreset_n),
    .pulse_1ms_i (pulse_1ms),
    .cfg_enb_i   (cfg_pwm_enb[1]),
    .cfg_high_i  (cfg_pwm1_high),
    .cfg_low_i   (cfg_pwm1_low),
    .waveform_o  (pwm_wfm[1])
  );

  pinmux_pad_mux u_pad_mux (
    .cfg_gpio_dir_i (cfg_gpio_dir),
    .cfg_gpio_out_i (cfg_gpio_out),
    .cfg_uart_enb_i (cfg_uart_enb),
    .cfg_pwm_enb_i  (cfg_pwm_enb),
    .pwm_wfm_i      (pwm_wfm),
    .uart_txd_i     (uart_txd_i),
    .pad_in_i       (pad_in_i),
    .pad_out_o      (pad_out_o),
    .pad_oen_o      (pad_oen_o),
    .uart_rxd_o     (uart_rxd_o),
    .pad_in_o       (pad_in_raw)
  );

endmodule

// ==== tb_pinmux_tasks.svh ====
// Bus tasks drive on the rising edge and expect the fixed one-wait-cycle ack of the register bank
//----------------------------------------------------------------------------
// Expected register model
//----------------------------------------------------------------------------
// Bits that hold a value, per offset
function automatic logic [31:0] impl_mask(input logic [7:0] addr);
  case (addr)
    REG_GPIO_DIR:   impl_mask = 32'h0000_00ff;
    REG_GPIO_OUT:   impl_mask = 32'h0000_00ff;
    REG_MULTI_FUNC: impl_mask = 32'h0000_0103;
    REG_PULSE_1US:  impl_mask = 32'h0000_03ff;
    REG_PWM0:       impl_mask = 32'hffff_ffff;
    REG_PWM1:       impl_mask = 32'hffff_ffff;
    // Read only or unmapped
    default:        impl_mask = 32'h0;
  endcase
endfunction

function automatic logic [31:0] read_model(input logic [7:0] addr);
  if (addr == REG_GPIO_IN) begin
    read_model = {24'h0, pad_in};
  end else if (impl_mask(addr) != 0) begin
    read_model = shadow[addr[4:2]];
  end else begin
    read_model = 32'h0;
  end
endfunction

// Ack expected one edge after the write edge
task automatic wait_ack();
  int n;
  n = 0;
  forever begin
    @(posedge mclk);
    if (reg_ack_o) begin
      break;
    end
    n++;
    if (n > 8) begin
      $display("Timeout while waiting for reg_ack_o at %0t", $time);
      timed_out = 1'b1;
      break;
    end
  end
endtask

task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
                         input logic [3:0] be);
  logic [31:0] m;
  m = impl_mask(addr) & {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  @(posedge mclk);
  reg_cs    <= 1'b1;
  reg_wr    <= 1'b1;
  reg_addr  <= addr;
  reg_wdata <= data;
  reg_be    <= be;
  // Write edge, model follows the DUT
  @(posedge mclk);
  if (m != 0) begin
    shadow[addr[4:2]] <= (shadow[addr[4:2]] & ~m) | (data & m);
  end
  wait_ack();
  reg_cs <= 1'b0;
  reg_wr <= 1'b0;
endtask

task automatic bus_read(input logic [7:0] addr);
  @(posedge mclk);
  exp_rdata <= read_model(addr);
  reg_cs    <= 1'b1;
  reg_wr    <= 1'b0;
  reg_addr  <= addr;
  reg_be    <= 4'($urandom);
  @(posedge mclk);
  wait_ack();
  reg_cs <= 1'b0;
endtask

task automatic idle(input int n);
  repeat (n) @(posedge mclk);
endtask

// Counts edges until pad 3 is sampled at the given level
task automatic wait_pwm_level(input logic lvl, input int max, output int cnt);
  cnt = 0;
  forever begin
    @(posedge mclk);
    cnt++;
    if (pad_out_o[PAD_PWM0] == lvl) begin
      break;
    end
    if (cnt > max) begin
      $display("Timeout while waiting for PWM0 pad level %0b at %0t", lvl, $time);
      timed_out = 1'b1;
      break;
    end
  end
endtask

// ==== tb_pinmux.sv ====
// Checks run as concurrent assertions against a register model kept by the bus tasks
`timescale 1ns/100ps

module tb_pinmux;

  import pinmux_pkg::*;

  logic              mclk;
  logic              arst_n;
  logic              reg_cs;
  logic              reg_wr;
  logic [REG_AW-1:0] reg_addr;
  logic [REG_DW-1:0] reg_wdata;
  logic [REG_BEW-1:0] reg_be;
  logic [REG_DW-1:0] reg_rdata_o;
  logic              reg_ack_o;
  logic [PAD_W-1:0]  pad_in;
  logic [PAD_W-1:0]  pad_out_o;
  logic [PAD_W-1:0]  pad_oen_o;
  logic              uart_txd;
  logic              uart_rxd_o;

  logic [31:0] shadow [0:7];
  logic [31:0] exp_rdata;
  logic        chk_en;
  logic        timed_out;
  logic        meas_vld;
  int          meas_lo;
  int          meas_hi;
  int          err_cnt;
  int          test_cnt;
  int          bad_tests;
  logic [PAD_W-1:0] exp_oen;
  logic [PAD_W-1:0] exp_out;
  logic [PAD_W-1:0] out_mask;
  logic             exp_rxd;

  `include "tb_pinmux_tasks.svh"

  pinmux_top i_dut (
    .mclk        (mclk),
    .arst_n_i    (arst_n),
    .reg_cs_i    (reg_cs),
    .reg_wr_i    (reg_wr),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_be_i    (reg_be),
    .reg_rdata_o (reg_rdata_o),
    .reg_ack_o   (reg_ack_o),
    .pad_in_i    (pad_in),
    .pad_out_o   (pad_out_o),
    .pad_oen_o   (pad_oen_o),
    .uart_txd_i  (uart_txd),
    .uart_rxd_o  (uart_rxd_o)
  );

  // 20 ns clock
  always #10 mclk = ~mclk;

  //--------------------------------------------------------------------------
  // Expected pads from the register model
  //--------------------------------------------------------------------------
  always_comb begin
    exp_oen  = '1;
    exp_out  = '0;
    out_mask = '1;
    for (int i = 0; i < PAD_W; i++) begin
      if (shadow[0][i]) begin
        exp_oen[i] = 1'b0;
        exp_out[i] = shadow[1][i];
      end
    end
    // Waveform level checked by measurement
    if (shadow[3][0]) begin
      exp_oen[PAD_PWM0]  = 1'b0;
      out_mask[PAD_PWM0] = 1'b0;
    end
    if (shadow[3][1]) begin
      exp_oen[PAD_PWM1]  = 1'b0;
      out_mask[PAD_PWM1] = 1'b0;
    end
    if (shadow[3][8]) begin
      exp_oen[PAD_UART_RXD] = 1'b1;
      exp_out[PAD_UART_RXD] = 1'b0;
      exp_oen[PAD_UART_TXD] = 1'b0;
      exp_out[PAD_UART_TXD] = uart_txd;
    end
    exp_rxd = shadow[3][8] & pad_in[PAD_UART_RXD];
  end

  //--------------------------------------------------------------------------
  // Checks
  //--------------------------------------------------------------------------
  a_pads: assert property (@(posedge mclk) disable iff (!chk_en)
    (pad_oen_o == exp_oen) && ((pad_out_o & out_mask) == (exp_out & out_mask)))
    else begin
      err_cnt++;
      $display("[FAIL] %0t pads oen=%h out=%h, expected oen=%h out=%h", $time,
               pad_oen_o, pad_out_o, exp_oen, exp_out);
    end

  a_rxd: assert property (@(posedge mclk) disable iff (!chk_en) uart_rxd_o == exp_rxd)
    else begin
      err_cnt++;
      $display("[FAIL] %0t uart_rxd_o=%b expected %b", $time, uart_rxd_o, exp_rxd);
    end

  // Ack for exactly one cycle, one cycle after cs
  a_ack_time: assert property (@(posedge mclk) disable iff (!chk_en)
    $rose(reg_cs) |-> !reg_ack_o ##1 reg_ack_o ##1 !reg_ack_o)
    else begin
      err_cnt++;
      $display("[FAIL] %0t ack not exactly one cycle after reg_cs_i", $time);
    end

  a_ack_idle: assert property (@(posedge mclk) disable iff (!chk_en)
    (!reg_cs && !$past(reg_cs)) |-> !reg_ack_o)
    else begin
      err_cnt++;
      $display("[FAIL] %0t reg_ack_o without an access", $time);
    end

  a_rdata: assert property (@(posedge mclk) disable iff (!chk_en)
    (reg_cs && !reg_wr && reg_ack_o) |-> (reg_rdata_o == exp_rdata))
    else begin
      err_cnt++;
      $display("[FAIL] %0t read addr %h data %h expected %h", $time, reg_addr,
               reg_rdata_o, exp_rdata);
    end

  // 2 ms high and 3 ms low at 2000 clocks per ms
  a_pwm_len: assert property (@(posedge mclk) meas_vld |-> (meas_lo == 6000 && meas_hi == 4000))
    else begin
      err_cnt++;
      $display("[FAIL] %0t PWM0 low %0d high %0d clocks, expected 6000 and 4000", $time,
               meas_lo, meas_hi);
    end

  task automatic report(input string name, input int err_before);
    test_cnt++;
    if (err_cnt != err_before || timed_out) begin
      bad_tests++;
      $display("test %0d %s: errors", test_cnt, name);
    end else begin
      $display("test %0d %s: ok", test_cnt, name);
    end
  endtask

  initial begin
    logic [7:0] addr;
    int e0;
    int cnt;
    mclk      = 1'b0;
    arst_n    = 1'b0;
    reg_cs    = 1'b0;
    reg_wr    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    reg_be    = '0;
    pad_in    = '0;
    uart_txd  = 1'b0;
    chk_en    = 1'b0;
    timed_out = 1'b0;
    meas_vld  = 1'b0;
    meas_lo   = 0;
    meas_hi   = 0;
    exp_rdata = '0;
    err_cnt   = 0;
    test_cnt  = 0;
    bad_tests = 0;
    for (int i = 0; i < 8; i++) begin
      shadow[i] = '0;
    end
    void'($urandom(32'hc773d2ff));

    repeat (3) @(posedge mclk);
    arst_n <= 1'b1;
    idle(3);
    chk_en <= 1'b1;

    // After reset, every offset reads zero
    e0 = err_cnt;
    for (int a = 0; a < 8; a++) begin
      bus_read(8'(a * 4));
    end
    report("reset", e0);

    // Random byte-enabled writes, unmapped offsets included
    e0 = err_cnt;
    for (int k = 0; k < 40; k++) begin
      addr = 8'(($urandom % 9) * 4);
      bus_write(addr, $urandom, 4'($urandom));
      bus_read(addr);
    end
    for (int a = 0; a < 8; a++) begin
      bus_write(8'(a * 4), 32'h0, 4'hf);
    end
    report("register access", e0);

    // GPIO rule and input synchronizer
    e0 = err_cnt;
    for (int k = 0; k < 10; k++) begin
      bus_write(REG_GPIO_DIR, $urandom, 4'hf);
      bus_write(REG_GPIO_OUT, $urandom, 4'hf);
      @(posedge mclk);
      pad_in <= 8'($urandom);
      idle(3);
      bus_read(REG_GPIO_IN);
    end
    report("gpio", e0);

    // UART owns pads 0 and 1
    e0 = err_cnt;
    bus_write(REG_GPIO_DIR, 32'h03, 4'hf);
    bus_write(REG_MULTI_FUNC, 32'h100, 4'hf);
    for (int k = 0; k < 20; k++) begin
      @(posedge mclk);
      pad_in   <= 8'($urandom);
      uart_txd <= 1'($urandom);
    end
    bus_write(REG_MULTI_FUNC, 32'h0, 4'hf);
    idle(4);
    report("uart override", e0);

    // PWM0 at 2000 clocks per ms
    e0 = err_cnt;
    bus_write(REG_GPIO_DIR, 32'h00, 4'hf);
    bus_write(REG_PULSE_1US, 32'h1, 4'hf);
    bus_write(REG_PWM0, {16'd3, 16'd2}, 4'hf);
    bus_write(REG_MULTI_FUNC, 32'h1, 4'hf);
    wait_pwm_level(1'b0, 20000, cnt);
    wait_pwm_level(1'b1, 20000, cnt);
    meas_lo = cnt;
    wait_pwm_level(1'b0, 20000, cnt);
    meas_hi = cnt;
    meas_vld <= 1'b1;
    @(posedge mclk);
    meas_vld <= 1'b0;
    bus_write(REG_MULTI_FUNC, 32'h3, 4'hf);
    idle(10);
    bus_write(REG_MULTI_FUNC, 32'h0, 4'hf);
    idle(4);
    report("pwm", e0);

    $display("tests: %0d, failed tests: %0d, failed checks: %0d", test_cnt, bad_tests,
             err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+.
pinmux_pkg.sv
pinmux_regs.sv
pinmux_tick_gen.sv
pinmux_pwm.sv
pinmux_pad_mux.sv
pinmux_top.sv
tb_pinmux.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the pin mux testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_pinmux -o sim_tb_pinmux
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb_pinmux > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi

if ! grep -q "Test completed successfully" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi

exit 0
